// File: source/out_fifo_pkg.sv
package out_fifo_pkg;

    localparam int sram_addr_w = 20;
    localparam int half_w      = 16;
    localparam int level_w     = sram_addr_w + 1;   // one spare bit to count a full ring

    // port of the external SRAM, strobes active low
    typedef struct packed {
        logic [sram_addr_w-1:0] addr;
        logic [half_w-1:0]      wdata;
        logic                   we_b;
        logic                   oe_b;
    } sram_req_t;

    // writer to ring controller
    typedef struct packed {
        logic              req;
        logic [half_w-1:0] data;
    } wr_req_t;

    typedef enum logic [1:0] {
        try_read  = 2'd3,
        read_sram = 2'd0,
        hold      = 2'd2
    } read_state_e;

    typedef enum logic [15:0] {
        reg_soft_rst   = 16'd0,
        reg_size_0     = 16'd1,
        reg_size_1     = 16'd2,
        reg_size_2     = 16'd3,
        reg_read_error = 16'd4
    } bus_reg_e;

endpackage

// File: source/sram_word_writer.sv
`timescale 1ns/1ps

module sram_word_writer (
    input  logic                  BUS_CLK,
    input  logic                  RST,
    input  logic                  fifo_empty_in,
    input  logic [31:0]           fifo_data,
    input  logic                  full,
    input  logic                  wr_grant,
    output out_fifo_pkg::wr_req_t wr_req,
    output logic                  fifo_read_next
);

    logic lower_half;   // low while the upper half of fifo_data is next

    always_ff @(posedge BUS_CLK) begin
        if (RST)
            lower_half <= 1'b0;
        else if (wr_grant)
            lower_half <= ~lower_half;
    end

    // request while upstream has a word and the ring has room
    always_comb begin
        wr_req.req = !fifo_empty_in && !full;
        if (lower_half)
            wr_req.data = fifo_data[15:0];
        else
            wr_req.data = fifo_data[31:16];
    end

    // word is done once its lower half is in the SRAM
    assign fifo_read_next = wr_grant && lower_half;

    // upstream is only popped when it really offers a word
    assert property (@(posedge BUS_CLK) disable iff (RST)
        fifo_read_next |-> !fifo_empty_in)
        else $error("fifo_read_next asserted while upstream is empty");

    // once the upper half is written the word has to stay put until its lower half goes
    assert property (@(posedge BUS_CLK) disable iff (RST)
        (wr_grant && !lower_half) |=> !fifo_empty_in)
        else $error("upstream went empty between the halves of a word");

endmodule

// File: source/sram_ring_ctrl.sv
`timescale 1ns/1ps

module sram_ring_ctrl #(
    parameter int DEPTH = 2**20
) (
    input  logic                             BUS_CLK,
    input  logic                             RST,
    input  out_fifo_pkg::wr_req_t            wr_req,
    input  logic                             rd_req,
    input  logic                             holding,
    output logic                             wr_grant,
    output out_fifo_pkg::sram_req_t          sram_req,
    output logic                             full,
    output logic                             empty,
    output logic [out_fifo_pkg::level_w-1:0] fifo_level
);

    localparam int aw = out_fifo_pkg::sram_addr_w;
    localparam int lw = out_fifo_pkg::level_w;

    if (DEPTH < 4 || DEPTH % 2 != 0 || DEPTH > 2**aw) begin : g_depth_check
        $error("DEPTH must be even, at least 4 and within the SRAM address range");
    end

    logic [aw-1:0] rd_ptr;
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr_next;
    logic [aw-1:0] wr_ptr_next;
    logic [lw-1:0] count;   // halves sitting in the SRAM

    // =========================================================================
    // pointers and fill count
    // =========================================================================

    assign rd_ptr_next = (rd_ptr == aw'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
    assign wr_ptr_next = (wr_ptr == aw'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (rd_req)
                rd_ptr <= rd_ptr_next;
            if (wr_grant) begin
                wr_ptr <= wr_ptr_next;
                count  <= count + 1'b1;
            end else if (rd_req) begin
                count  <= count - 1'b1;
            end
        end
    end

    assign empty      = (count == '0);
    assign full       = (count == lw'(DEPTH));
    assign fifo_level = count + lw'(holding);   // the half in the reader still counts

    // =========================================================================
    // single SRAM port, a read always wins
    // =========================================================================

    assign wr_grant = wr_req.req && !rd_req;

    always_comb begin
        sram_req.addr  = rd_req ? rd_ptr : wr_ptr;
        sram_req.wdata = wr_req.data;
        sram_req.we_b  = !wr_grant;
        sram_req.oe_b  = !rd_req;
    end

    assert property (@(posedge BUS_CLK) disable iff (RST) wr_grant |-> !full)
        else $error("write granted into a full ring");

    assert property (@(posedge BUS_CLK) disable iff (RST) rd_req |-> !empty)
        else $error("read pointer pushed past the write pointer");

    // pointers meet only when the ring is completely empty or completely full
    assert property (@(posedge BUS_CLK) disable iff (RST)
        (full || empty) |-> (wr_ptr == rd_ptr))
        else $error("ring pointers out of step with the fill count");

endmodule

// File: source/usb_byte_reader.sv
`timescale 1ns/1ps

module usb_byte_reader (
    input  logic                            BUS_CLK,
    input  logic                            RST,
    input  logic                            usb_read,
    input  logic                            empty,
    input  logic [out_fifo_pkg::half_w-1:0] sram_rdata,
    output logic                            rd_req,
    output logic                            holding,
    output logic [7:0]                      usb_data,
    output logic [7:0]                      read_error
);

    out_fifo_pkg::read_state_e state;
    out_fifo_pkg::read_state_e state_next;

    logic [out_fifo_pkg::half_w-1:0] half_q;   // prefetched half
    logic                            lower_byte;

    // =========================================================================
    // read FSM
    // =========================================================================

    always_ff @(posedge BUS_CLK) begin
        if (RST)
            state <= out_fifo_pkg::try_read;
        else
            state <= state_next;
    end

    always_comb begin
        state_next = state;
        case (state)
            out_fifo_pkg::try_read:
                if (!empty)
                    state_next = out_fifo_pkg::read_sram;
            out_fifo_pkg::read_sram:
                state_next = out_fifo_pkg::hold;
            out_fifo_pkg::hold:
                if (usb_read && lower_byte)   // lower byte taken, half released
                    state_next = empty ? out_fifo_pkg::try_read : out_fifo_pkg::read_sram;
            default:
                state_next = out_fifo_pkg::try_read;
        endcase
    end

    assign rd_req  = (state == out_fifo_pkg::read_sram);
    assign holding = (state == out_fifo_pkg::hold);

    // =========================================================================
    // holding register and byte select
    // =========================================================================

    always_ff @(posedge BUS_CLK) begin
        if (rd_req)
            half_q <= sram_rdata;
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST)
            lower_byte <= 1'b0;
        else if (rd_req)
            lower_byte <= 1'b0;   // a new half starts with its upper byte
        else if (usb_read && holding)
            lower_byte <= ~lower_byte;
    end

    assign usb_data = lower_byte ? half_q[7:0] : half_q[15:8];

    // host reads with nothing to give, saturates
    always_ff @(posedge BUS_CLK) begin
        if (RST)
            read_error <= '0;
        else if (usb_read && empty && !holding && read_error != 8'hff)
            read_error <= read_error + 1'b1;
    end

endmodule

// File: source/fifo_conf_regs.sv
`timescale 1ns/1ps

module fifo_conf_regs (
    input  logic                             BUS_CLK,
    input  logic                             RST,
    input  logic [15:0]                      bus_add,
    input  logic [7:0]                       bus_data_in,
    input  logic                             bus_wr,
    input  logic                             bus_rd,
    input  logic [out_fifo_pkg::level_w-1:0] fifo_level,
    input  logic [7:0]                       read_error,
    output logic [7:0]                       bus_data_out,
    output logic                             soft_rst
);

    // any write to address 0 clears the FIFO whatever the data byte
    assign soft_rst = bus_wr && (bus_add == out_fifo_pkg::reg_soft_rst);

    always_comb begin
        bus_data_out = 8'h00;   // unmapped addresses read as zero
        case (bus_add)
            out_fifo_pkg::reg_size_0:
                bus_data_out = fifo_level[7:0];
            out_fifo_pkg::reg_size_1:
                bus_data_out = fifo_level[15:8];
            out_fifo_pkg::reg_size_2:
                bus_data_out = 8'(fifo_level[out_fifo_pkg::level_w-1:16]);
            out_fifo_pkg::reg_read_error:
                bus_data_out = read_error;
            default:
                bus_data_out = 8'h00;
        endcase
    end

    // bus master issues either a read or a write per cycle
    assert property (@(posedge BUS_CLK) disable iff (RST) !(bus_wr && bus_rd))
        else $error("bus read and write in the same cycle");

    assert property (@(posedge BUS_CLK) disable iff (RST)
        bus_wr |-> !$isunknown({bus_add, bus_data_in}))
        else $error("bus write with unknown address or data");

endmodule

// File: source/out_fifo.sv
`timescale 1ns/1ps

module out_fifo #(
    parameter int DEPTH = 2**20
) (
    input  logic                            BUS_CLK,
    input  logic                            RST,
    input  logic [15:0]                     bus_add,
    input  logic [7:0]                      bus_data_in,
    input  logic                            bus_rd,
    input  logic                            bus_wr,
    output logic [7:0]                      bus_data_out,
    output out_fifo_pkg::sram_req_t         sram_req,
    input  logic [out_fifo_pkg::half_w-1:0] sram_rdata,
    input  logic                            usb_read,
    output logic [7:0]                      usb_data,
    input  logic                            fifo_empty_in,
    input  logic [31:0]                     fifo_data,
    output logic                            fifo_read_next,
    output logic                            fifo_not_empty,
    output logic                            fifo_read_error
);

    logic                             soft_rst;
    logic                             fifo_rst;
    out_fifo_pkg::wr_req_t            wr_req;
    logic                             wr_grant;
    logic                             full;
    logic                             empty;
    logic                             rd_req;
    logic                             holding;
    logic [out_fifo_pkg::level_w-1:0] fifo_level;
    logic [7:0]                       read_error;

    assign fifo_rst = RST | soft_rst;

    // SRAM byte lanes and chip select stay enabled, only we_b and oe_b toggle

    sram_word_writer u_writer (
        .BUS_CLK        (BUS_CLK),
        .RST            (fifo_rst),
        .fifo_empty_in  (fifo_empty_in),
        .fifo_data      (fifo_data),
        .full           (full),
        .wr_grant       (wr_grant),
        .wr_req         (wr_req),
        .fifo_read_next (fifo_read_next)
    );

    sram_ring_ctrl #(
        .DEPTH (DEPTH)
    ) u_ring (
        .BUS_CLK    (BUS_CLK),
        .RST        (fifo_rst),
        .wr_req     (wr_req),
        .rd_req     (rd_req),
        .holding    (holding),
        .wr_grant   (wr_grant),
        .sram_req   (sram_req),
        .full       (full),
        .empty      (empty),
        .fifo_level (fifo_level)
    );

    usb_byte_reader u_reader (
        .BUS_CLK    (BUS_CLK),
        .RST        (fifo_rst),
        .usb_read   (usb_read),
        .empty      (empty),
        .sram_rdata (sram_rdata),
        .rd_req     (rd_req),
        .holding    (holding),
        .usb_data   (usb_data),
        .read_error (read_error)
    );

    fifo_conf_regs u_regs (
        .BUS_CLK      (BUS_CLK),
        .RST          (RST),   // soft reset is generated here
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .fifo_level   (fifo_level),
        .read_error   (read_error),
        .bus_data_out (bus_data_out),
        .soft_rst     (soft_rst)
    );

    assign fifo_not_empty  = !empty;
    assign fifo_read_error = (read_error != 8'h00);

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic BUS_CLK,
    output logic RST
);

    initial begin
        BUS_CLK = 1'b0;
        forever #5 BUS_CLK = ~BUS_CLK;   // 10 ns period
    end

    initial begin
        RST = 1'b1;
        repeat (5) @(posedge BUS_CLK);
        RST <= 1'b0;
    end

endmodule

// File: testbench/sram_model.sv
`timescale 1ns/1ps

module sram_model #(
    parameter int DEPTH = 16
) (
    input  logic                            BUS_CLK,
    input  out_fifo_pkg::sram_req_t         sram_req,
    output logic [out_fifo_pkg::half_w-1:0] sram_rdata
);

    logic [out_fifo_pkg::half_w-1:0] mem [DEPTH];

    // data bus floats unless output enable is low
    assign sram_rdata = sram_req.oe_b ? 'z : mem[sram_req.addr];

    always @(posedge BUS_CLK) begin
        if (!sram_req.we_b)
            mem[sram_req.addr] <= sram_req.wdata;   // write lands on the clock edge
    end

endmodule

// File: testbench/tb_out_fifo.sv
`timescale 1ns/1ps

module tb_out_fifo;

    localparam int DEPTH = 16;
    localparam int lw    = out_fifo_pkg::level_w;
    localparam int budget_cycles = 300 + 250 + 450 + 700 + 100;   // tests 1 to 5

    logic        BUS_CLK;
    logic        RST;
    logic [15:0] bus_add;
    logic [7:0]  bus_data_in;
    logic [7:0]  bus_data_out;
    logic        bus_rd;
    logic        bus_wr;
    out_fifo_pkg::sram_req_t         sram_req;
    logic [out_fifo_pkg::half_w-1:0] sram_rdata;
    logic        usb_read;
    logic [7:0]  usb_data;
    logic        fifo_empty_in;
    logic [31:0] fifo_data;
    logic        fifo_read_next;
    logic        fifo_not_empty;
    logic        fifo_read_error;

    logic [31:0]   up_q[$];    // upstream words with the front one on fifo_data
    logic [7:0]    exp_q[$];   // bytes the USB side still owes in order
    logic [lw-1:0] level;
    logic [7:0]    rd_byte;

    tb_clock_gen u_clk (.BUS_CLK, .RST);
    sram_model #(.DEPTH(DEPTH)) u_sram (.BUS_CLK, .sram_req, .sram_rdata);
    out_fifo #(.DEPTH(DEPTH)) u_out_fifo (.*);

    // upstream pops on fifo_read_next and shows the next word one cycle later
    always @(posedge BUS_CLK) begin
        if (fifo_read_next && up_q.size() != 0)
            void'(up_q.pop_front());
        fifo_empty_in <= (up_q.size() == 0);
        fifo_data     <= (up_q.size() == 0) ? 32'h0 : up_q[0];
    end

    initial begin
        #(budget_cycles * 10 * 2);
        $display("timeout, tests did not finish within %0d cycles", budget_cycles * 2);
        stop_run();
    end

    // =========================================================================
    // checks and bus helpers
    // =========================================================================

    task automatic stop_run();
        $display("TEST FAIL");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic compare_byte(input string name, input logic [7:0] got,
                                input logic [7:0] want);
        if (got !== want) begin
            $display("[ERROR] %s = 0x%02h, expected 0x%02h", name, got, want);
            stop_run();
        end
    endtask

    task automatic compare_level(input string name, input logic [lw-1:0] got,
                                 input logic [lw-1:0] want);
        if (got !== want) begin
            $display("[ERROR] %s = 0x%0h, expected 0x%0h", name, got, want);
            stop_run();
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("[ERROR] %s = 0x%0h, expected 0x%0h", name, got, want);
            stop_run();
        end
    endtask

    task automatic push_word(input logic [31:0] w);
        @(negedge BUS_CLK);
        up_q.push_back(w);
        for (int i = 3; i >= 0; i--)
            exp_q.push_back(w[8*i +: 8]);   // msb byte leaves first
    endtask

    task automatic read_reg(input logic [15:0] addr, output logic [7:0] data);
        @(posedge BUS_CLK);
        bus_add <= addr;
        bus_rd  <= 1'b1;
        @(negedge BUS_CLK);
        data = bus_data_out;
        @(posedge BUS_CLK);
        bus_rd <= 1'b0;
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        bus_add     <= addr;
        bus_data_in <= data;
        bus_wr      <= 1'b1;
        @(posedge BUS_CLK);
        bus_wr <= 1'b0;
    endtask

    task automatic read_level(output logic [lw-1:0] lv);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        read_reg(out_fifo_pkg::reg_size_0, b0);
        read_reg(out_fifo_pkg::reg_size_1, b1);
        read_reg(out_fifo_pkg::reg_size_2, b2);
        lv = lw'({b2, b1, b0});
    endtask

    task automatic wait_level(input logic [lw-1:0] target);
        logic [lw-1:0] lv;
        int            tries;
        tries = 0;
        read_level(lv);
        while (lv !== target && tries < 100) begin
            read_level(lv);
            tries++;
        end
        if (lv !== target) begin
            $display("fill level never reached %0d, last read %0d", target, lv);
            stop_run();
        end
        repeat (3) @(posedge BUS_CLK);   // let the reader prefetch
    endtask

    // the last word is gone once upstream reports empty with nothing queued
    task automatic wait_upstream_drained();
        int cycles;
        cycles = 0;
        @(negedge BUS_CLK);
        while (!(fifo_empty_in && up_q.size() == 0) && cycles < 200) begin
            @(negedge BUS_CLK);
            cycles++;
        end
        if (!(fifo_empty_in && up_q.size() == 0)) begin
            $display("writer never took all upstream words");
            stop_run();
        end
    endtask

    task automatic pulse_usb_read();
        @(posedge BUS_CLK);
        usb_read <= 1'b1;
        @(posedge BUS_CLK);
        usb_read <= 1'b0;
    endtask

    task automatic check_next_byte();
        logic [7:0] want;
        if (exp_q.size() == 0) begin
            $display("USB read attempted with no byte left in the expected stream");
            stop_run();
        end
        want = exp_q.pop_front();
        @(negedge BUS_CLK);
        compare_byte("usb_data", usb_data, want);
        pulse_usb_read();
        repeat (3) @(posedge BUS_CLK);   // host spacing
    endtask

    task automatic drain();
        while (exp_q.size() != 0)
            check_next_byte();
    endtask

    // =========================================================================
    // directed tests
    // =========================================================================

    task automatic ordered_delivery();
        repeat (5) push_word($urandom());
        wait_level(lw'(10));
        repeat (20) check_next_byte();
    endtask

    task automatic fill_level_readback();
        repeat (3) push_word($urandom());
        wait_upstream_drained();
        read_level(level);
        compare_level("fifo_level", level, lw'(6));
        repeat (2) check_next_byte();
        read_level(level);
        compare_level("fifo_level", level, lw'(5));
        drain();
    endtask

    task automatic full_back_pressure();
        repeat (12) push_word($urandom());
        wait_level(lw'(DEPTH + 1));   // full ring plus the held half
        repeat (20) begin
            @(negedge BUS_CLK);
            compare_flag("fifo_read_next", fifo_read_next, 1'b0);
        end
        compare_flag("fifo_empty_in", fifo_empty_in, 1'b0);
        drain();
    endtask

    task automatic empty_read_errors();
        repeat (3) pulse_usb_read();
        read_reg(out_fifo_pkg::reg_read_error, rd_byte);
        compare_byte("read_error", rd_byte, 8'h03);
        @(negedge BUS_CLK);
        compare_flag("fifo_read_error", fifo_read_error, 1'b1);
        repeat (300) pulse_usb_read();
        read_reg(out_fifo_pkg::reg_read_error, rd_byte);
        compare_byte("read_error", rd_byte, 8'hff);
    endtask

    task automatic soft_reset_clears();
        repeat (4) push_word($urandom());
        wait_level(lw'(8));
        @(negedge BUS_CLK);
        compare_flag("fifo_not_empty", fifo_not_empty, 1'b1);
        write_reg(out_fifo_pkg::reg_soft_rst, 8'($urandom()));
        exp_q.delete();
        @(negedge BUS_CLK);
        compare_flag("fifo_not_empty", fifo_not_empty, 1'b0);
        compare_flag("fifo_read_error", fifo_read_error, 1'b0);
        read_level(level);
        compare_level("fifo_level", level, '0);
        read_reg(out_fifo_pkg::reg_read_error, rd_byte);
        compare_byte("read_error", rd_byte, 8'h00);
    endtask

    initial begin
        bus_add       = '0;
        bus_data_in   = '0;
        bus_rd        = 1'b0;
        bus_wr        = 1'b0;
        usb_read      = 1'b0;
        fifo_empty_in = 1'b1;
        fifo_data     = '0;
        void'($urandom(2286));
        @(negedge RST);
        @(posedge BUS_CLK);
        ordered_delivery();
        fill_level_readback();
        full_back_pressure();
        empty_read_errors();
        soft_reset_clears();
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: out_fifo.f
source/out_fifo_pkg.sv
source/sram_word_writer.sv
source/sram_ring_ctrl.sv
source/usb_byte_reader.sv
source/fifo_conf_regs.sv
source/out_fifo.sv
testbench/tb_clock_gen.sv
testbench/sram_model.sv
testbench/tb_out_fifo.sv
